// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= tb_amiv
RTL_TOP   ?= amiv_top
FILELIST  ?= sources.f
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== rtl/amiv_cfg.svh ====
// Geometry of the capture window and of the doubled output raster.
// Included by the package and by every block that compares raster counters.
`ifndef AMIV_CFG_SVH
`define AMIV_CFG_SVH

`define AMIV_CAP_W 8 // stored pixels per line.
`define AMIV_CAP_H 4 // stored lines per frame.

`define AMIV_IN_HBLANK 3 // input pixels skipped before the window opens.
`define AMIV_IN_VBLANK 2 // input lines skipped before the window opens.

`define AMIV_OUT_HFP 2 // output pixels before hsync.
`define AMIV_OUT_HSW 2 // hsync width in output pixels.
`define AMIV_OUT_HBP 2 // output pixels after hsync.

`define AMIV_OUT_VFP 1 // output lines before vsync.
`define AMIV_OUT_VSW 1 // vsync width in output lines.
`define AMIV_OUT_VBP 1 // output lines after vsync.
`define AMIV_OUT_VOFF 1 // extra lines that push the picture down.

// blanking and totals follow from the values above.
`define AMIV_OUT_HBLANK (`AMIV_OUT_HFP + `AMIV_OUT_HSW + `AMIV_OUT_HBP)
`define AMIV_OUT_VBLANK (`AMIV_OUT_VFP + `AMIV_OUT_VSW + `AMIV_OUT_VBP)
`define AMIV_OUT_HTOTAL (`AMIV_OUT_HBLANK + 2 * `AMIV_CAP_W)
`define AMIV_OUT_VTOTAL (`AMIV_OUT_VBLANK + `AMIV_OUT_VOFF + 2 * `AMIV_CAP_H)

`define AMIV_ADDR_W 19 // the external SRAM has 512k words.
`define AMIV_CNT_W 12 // every raster counter uses this width.

`endif

// ==== rtl/amiv_if.sv ====
// Internal links of the scan doubler.
// wr_port_if carries packed pixels to the SRAM sequencer, scan_if ties it to the output raster.
`timescale 1ns/1ps
`default_nettype none

interface wr_port_if import amiv_pkg::*; ();
	logic       pending; // a packed pixel waits for its write slot.
	sram_addr_t wr_addr;
	pix565_t    wr_data;
	logic       taken; // pulses in the write slot that stores the word.

	modport source (output pending, output wr_addr, output wr_data, input taken);
	modport sink (input pending, input wr_addr, input wr_data, output taken);
endinterface

interface scan_if import amiv_pkg::*; ();
	logic       pix_tick; // one output pixel has passed.
	logic       read_slot; // the SRAM is free for a read in this clock.
	logic       in_window; // the raster is inside the visible picture.
	sram_addr_t rd_addr;

	modport timing (input pix_tick, input read_slot, output in_window, output rd_addr);
	modport sequencer (output pix_tick, output read_slot, input in_window, input rd_addr);
endinterface

`default_nettype wire

// ==== rtl/amiv_pkg.sv ====
// Pixel formats and the sequencer phase shared by the scan doubler and its testbench.
// Import with a wildcard in the module header.
`default_nettype none
`include "amiv_cfg.svh"

package amiv_pkg;
	typedef struct packed {
		logic [9:0] r; // red sits in the top bits as on the digitizer bus.
		logic [9:0] g;
		logic [9:0] b;
	} pix30_t;

	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g; // green keeps one extra bit.
		logic [4:0] b;
	} pix565_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb888_t;

	typedef enum logic [1:0] {ph_show = 2'd0, ph_write = 2'd1, ph_show2 = 2'd2, ph_read = 2'd3} seq_phase_t;

	typedef logic [`AMIV_ADDR_W-1:0] sram_addr_t;
endpackage

`default_nettype wire

// ==== rtl/amiv_top.sv ====
// Top level of the scan doubler.
// Connects capture, output timing and the SRAM sequencer to the board pins.
`timescale 1ns/1ps
`default_nettype none

module amiv_top import amiv_pkg::*; (
	input  logic       in_hs,
	input  logic       arst_n,
	input  logic       scan_en,
	input  logic       pix_stb,
	input  logic       line_sync,
	input  logic       frame_sync,
	input  pix30_t     in_data,
	input  pix565_t    sram_rdata,
	output logic       out_pclk,
	output logic       out_hs,
	output logic       out_vs,
	output logic       out_de,
	output rgb888_t    out_data,
	output logic       sram_oe_n,
	output logic       sram_we_n,
	output sram_addr_t sram_addr,
	output pix565_t    sram_wdata
);
	wr_port_if wr_bus (); // packed pixels waiting for the SRAM.
	scan_if    scan_bus (); // raster position and read slots.

	assign out_de = 1'b1; // the HDMI transmitter makes its own data enable.

	pixel_capture u_capture (
		.in_hs      (in_hs),
		.arst_n     (arst_n),
		.pix_stb    (pix_stb),
		.line_sync  (line_sync),
		.frame_sync (frame_sync),
		.in_data    (in_data),
		.wr         (wr_bus)
	);

	scan_timing u_timing (
		.in_hs   (in_hs),
		.arst_n  (arst_n),
		.scan_en (scan_en),
		.scan    (scan_bus),
		.out_hs  (out_hs),
		.out_vs  (out_vs)
	);

	sram_sequencer u_seq (
		.in_hs      (in_hs),
		.arst_n     (arst_n),
		.scan_en    (scan_en),
		.wr         (wr_bus),
		.scan       (scan_bus),
		.sram_rdata (sram_rdata),
		.sram_addr  (sram_addr),
		.sram_wdata (sram_wdata),
		.sram_we_n  (sram_we_n),
		.sram_oe_n  (sram_oe_n),
		.out_pclk   (out_pclk),
		.out_data   (out_data)
	);
endmodule

`default_nettype wire

// ==== rtl/pixel_capture.sv ====
// Input side of the scan doubler.
// Counts digitizer pixels and lines and turns each pixel inside the capture window
// into an RGB565 word with its SRAM address, held until the sequencer stores it.
`timescale 1ns/1ps
`default_nettype none
`include "amiv_cfg.svh"

module pixel_capture import amiv_pkg::*; (
	input  logic      in_hs,
	input  logic      arst_n,
	input  logic      pix_stb,
	input  logic      line_sync,
	input  logic      frame_sync,
	input  pix30_t    in_data,
	wr_port_if.source wr
);
	localparam logic [`AMIV_CNT_W-1:0] h_first = `AMIV_CNT_W'(`AMIV_IN_HBLANK);
	localparam logic [`AMIV_CNT_W-1:0] h_end = `AMIV_CNT_W'(`AMIV_IN_HBLANK + `AMIV_CAP_W);
	localparam logic [`AMIV_CNT_W-1:0] v_first = `AMIV_CNT_W'(`AMIV_IN_VBLANK);
	localparam logic [`AMIV_CNT_W-1:0] v_end = `AMIV_CNT_W'(`AMIV_IN_VBLANK + `AMIV_CAP_H);

	logic                   line_sync_q;
	logic                   line_rise;
	logic [`AMIV_CNT_W-1:0] pix_cnt;
	logic [`AMIV_CNT_W-1:0] line_cnt;
	logic [`AMIV_CNT_W-1:0] pix_off;
	logic [`AMIV_CNT_W-1:0] line_off;
	logic                   in_win;
	logic                   capture;
	pix565_t                pix_565;

	assign line_rise = line_sync & ~line_sync_q; // a new input line starts here.
	assign in_win = (pix_cnt >= h_first) && (pix_cnt < h_end) &&
			(line_cnt >= v_first) && (line_cnt < v_end); // counters point at a stored pixel.
	assign capture = pix_stb && line_sync && in_win; // this strobe carries a pixel to keep.
	assign pix_off = pix_cnt - h_first; // column inside the stored line.
	assign line_off = line_cnt - v_first; // row inside the stored frame.

	assign pix_565.r = in_data.r[9:5]; // only the top bits of each colour survive.
	assign pix_565.g = in_data.g[9:4];
	assign pix_565.b = in_data.b[9:5];

	always_ff @(posedge in_hs or negedge arst_n) begin
		if (!arst_n) begin
			line_sync_q <= 1'b0;
			pix_cnt <= '0;
			line_cnt <= '0;
		end else begin
			line_sync_q <= line_sync;
			if (!line_sync) begin
				pix_cnt <= '0; // the pixel count restarts in every horizontal sync.
			end else if (pix_stb) begin
				pix_cnt <= pix_cnt + 1'b1;
			end
			if (!frame_sync) begin
				line_cnt <= '0; // vertical sync restarts the line count.
			end else if (line_rise) begin
				line_cnt <= line_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge in_hs or negedge arst_n) begin
		if (!arst_n) begin
			wr.pending <= 1'b0;
		end else if (capture) begin
			wr.pending <= 1'b1; // a fresh strobe replaces any word still waiting.
		end else if (wr.taken) begin
			wr.pending <= 1'b0;
		end
	end

	always_ff @(posedge in_hs) begin
		if (capture) begin
			wr.wr_addr <= sram_addr_t'(line_off) * sram_addr_t'(`AMIV_CAP_W) +
					sram_addr_t'(pix_off); // stored lines sit back to back in SRAM.
			wr.wr_data <= pix_565;
		end
	end
endmodule

`default_nettype wire

// ==== rtl/scan_timing.sv ====
// Output raster of the scan doubler.
// Counts output pixels and lines on pix_tick, makes both syncs and the display window,
// and walks the SRAM read pointer so that every stored line is shown twice.
`timescale 1ns/1ps
`default_nettype none
`include "amiv_cfg.svh"

module scan_timing import amiv_pkg::*; (
	input  logic     in_hs,
	input  logic     arst_n,
	input  logic     scan_en,
	scan_if.timing   scan,
	output logic     out_hs,
	output logic     out_vs
);
	localparam logic [`AMIV_CNT_W-1:0] h_last = `AMIV_CNT_W'(`AMIV_OUT_HTOTAL - 1);
	localparam logic [`AMIV_CNT_W-1:0] h_win = `AMIV_CNT_W'(`AMIV_OUT_HBLANK);
	localparam logic [`AMIV_CNT_W-1:0] hs_on = `AMIV_CNT_W'(`AMIV_OUT_HFP);
	localparam logic [`AMIV_CNT_W-1:0] hs_off = `AMIV_CNT_W'(`AMIV_OUT_HFP + `AMIV_OUT_HSW);
	localparam logic [`AMIV_CNT_W-1:0] v_last = `AMIV_CNT_W'(`AMIV_OUT_VTOTAL - 1);
	localparam logic [`AMIV_CNT_W-1:0] v_win = `AMIV_CNT_W'(`AMIV_OUT_VBLANK + `AMIV_OUT_VOFF);
	localparam logic [`AMIV_CNT_W-1:0] vs_on = `AMIV_CNT_W'(`AMIV_OUT_VBP);
	localparam logic [`AMIV_CNT_W-1:0] vs_off = `AMIV_CNT_W'(`AMIV_OUT_VBP + `AMIV_OUT_VSW);
	localparam sram_addr_t line_words = sram_addr_t'(`AMIV_CAP_W);

	logic [`AMIV_CNT_W-1:0] pix_cnt;
	logic [`AMIV_CNT_W-1:0] line_cnt;
	sram_addr_t             rd_cnt;
	logic                   line_twice; // set while the second copy of a line is shown.
	logic                   line_end;
	logic                   frame_end;

	assign line_end = scan.pix_tick && (pix_cnt == h_last); // the last pixel of a line passes.
	assign frame_end = line_end && (line_cnt == v_last);
	assign scan.in_window = (pix_cnt >= h_win) && (line_cnt >= v_win); // both run to the total.
	assign scan.rd_addr = rd_cnt;

	always_ff @(posedge in_hs or negedge arst_n) begin
		if (!arst_n) begin
			pix_cnt <= '0;
			line_cnt <= '0;
		end else if (scan.pix_tick) begin
			if (pix_cnt == h_last) begin
				pix_cnt <= '0;
				line_cnt <= (line_cnt == v_last) ? '0 : line_cnt + 1'b1;
			end else begin
				pix_cnt <= pix_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge in_hs or negedge arst_n) begin
		if (!arst_n) begin
			rd_cnt <= '0;
			line_twice <= 1'b0;
		end else if (frame_end) begin
			rd_cnt <= '0; // the next frame reads from the first stored pixel.
			line_twice <= 1'b0;
		end else if (line_end) begin
			if (!line_twice && (rd_cnt != '0)) begin
				rd_cnt <= rd_cnt - line_words; // go back and show the same stored line again.
			end
			line_twice <= ~line_twice;
		end else if (scan.read_slot && scan.in_window) begin
			rd_cnt <= rd_cnt + 1'b1; // one stored pixel per read slot.
		end
	end

	always_ff @(posedge in_hs or negedge arst_n) begin
		if (!arst_n) begin
			out_hs <= 1'b0;
			out_vs <= 1'b0;
		end else begin
			out_hs <= scan_en && (pix_cnt >= hs_on) && (pix_cnt < hs_off); // syncs lag a clock.
			out_vs <= scan_en && (line_cnt >= vs_on) && (line_cnt < vs_off);
		end
	end
endmodule

`default_nettype wire

// ==== rtl/sram_sequencer.sv ====
// SRAM slot machine of the scan doubler.
// Four phases share the SRAM between pending writes and raster reads, and the fetched
// RGB565 words come out as 24-bit pixels with their own pixel clock.
`timescale 1ns/1ps
`default_nettype none

module sram_sequencer import amiv_pkg::*; (
	input  logic       in_hs,
	input  logic       arst_n,
	input  logic       scan_en,
	wr_port_if.sink    wr,
	scan_if.sequencer  scan,
	input  pix565_t    sram_rdata,
	output sram_addr_t sram_addr,
	output pix565_t    sram_wdata,
	output logic       sram_we_n,
	output logic       sram_oe_n,
	output logic       out_pclk,
	output rgb888_t    out_data
);
	seq_phase_t phase;
	logic       write_go;
	logic       read_go;
	rgb888_t    expanded;

	always_ff @(posedge in_hs or negedge arst_n) begin
		if (!arst_n) begin
			phase <= ph_show;
		end else if (!scan_en) begin
			phase <= ph_show; // the machine parks while scanning is off.
		end else begin
			case (phase)
				ph_show:  phase <= ph_write;
				ph_write: phase <= ph_show2;
				ph_show2: phase <= ph_read;
				default:  phase <= ph_show;
			endcase
		end
	end

	assign write_go = (phase == ph_write) && wr.pending; // a waiting pixel gets this slot.
	assign read_go = (phase == ph_read) && scan.in_window;
	assign wr.taken = write_go;

	assign scan.pix_tick = scan_en && ((phase == ph_show) || (phase == ph_show2));
	assign scan.read_slot = (phase == ph_read);

	assign sram_we_n = ~write_go; // one clock of write strobe per stored pixel.
	assign sram_oe_n = write_go; // outputs are released only while the bus is written.
	assign sram_wdata = wr.wr_data;

	always_comb begin
		if (write_go) begin
			sram_addr = wr.wr_addr;
		end else if (read_go) begin
			sram_addr = scan.rd_addr;
		end else begin
			sram_addr = '0;
		end
	end

	assign expanded.r = {sram_rdata.r, 3'b000}; // the lost low bits come back as zeros.
	assign expanded.g = {sram_rdata.g, 2'b00};
	assign expanded.b = {sram_rdata.b, 3'b000};

	always_ff @(posedge in_hs or negedge arst_n) begin
		if (!arst_n) begin
			out_pclk <= 1'b0;
			out_data <= '0;
		end else begin
			out_pclk <= scan.pix_tick; // high in the clock after each output pixel step.
			if (!scan_en) begin
				out_data <= '0;
			end else if (phase == ph_read) begin
				if (scan.in_window) begin
					out_data <= expanded; // this word shows for two output pixels.
				end else begin
					out_data <= '0; // blanking is black.
				end
			end
		end
	end
endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+rtl
rtl/amiv_pkg.sv
rtl/amiv_if.sv
rtl/pixel_capture.sv
rtl/scan_timing.sv
rtl/sram_sequencer.sv
rtl/amiv_top.sv
testbench/amiv_checker.sv
testbench/tb_amiv.sv

// ==== testbench/amiv_checker.sv ====
// Scoreboard of the scan doubler testbench.
// Predicts every SRAM write from the capture window and keeps a shadow memory. Checks the
// sync timing, then compares every output pixel and read address of one frame after the writes.
`timescale 1ns/1ps
`default_nettype none
`include "amiv_cfg.svh"

module amiv_checker import amiv_pkg::*; (
	input  logic        in_hs,
	input  logic        arst_n,
	input  logic        scan_en,
	input  logic [15:0] exp_words [0:2*`AMIV_CAP_W-1],
	input  logic        out_pclk,
	input  logic        out_hs,
	input  logic        out_vs,
	input  logic        out_de,
	input  rgb888_t     out_data,
	input  logic        sram_we_n,
	input  logic        sram_oe_n,
	input  sram_addr_t  sram_addr,
	input  pix565_t     sram_wdata,
	output logic        done,
	output int          reset_errs,
	output int          write_errs,
	output int          raster_errs,
	output int          pixel_errs
);
	localparam int n_words = `AMIV_CAP_W * `AMIV_CAP_H;
	localparam int h_total = `AMIV_OUT_HTOTAL;
	localparam int v_first = `AMIV_OUT_VBLANK + `AMIV_OUT_VOFF;

	pix565_t shadow [0:n_words-1]; // what the SRAM must hold after the input frame.
	int      wr_cnt = 0;
	int      clk_cnt = 0;
	int      hs_rise_at = 0;
	int      hs_lines = 0;
	int      pix_pos = 0; // index of the next output pixel.
	int      line_pos = 0;
	logic    hs_q = 1'b0;
	logic    vs_q = 1'b0;
	logic    hs_seen = 1'b0;
	logic    vs_seen = 1'b0;
	logic    tracking = 1'b0; // raster position is known after the first vsync.
	logic    checking = 1'b0;

	initial begin
		done = 1'b0;
		reset_errs = 0;
		write_errs = 0;
		raster_errs = 0;
		pixel_errs = 0;
	end

	function automatic rgb888_t expand(input pix565_t w);
		rgb888_t e;
		e.r = {w.r, 3'b000}; // each field fills the top bits of its byte.
		e.g = {w.g, 2'b00};
		e.b = {w.b, 3'b000};
		return e;
	endfunction

	always @(negedge in_hs) begin
		int      row;
		int      col;
		pix565_t exp_w;
		rgb888_t exp_rgb;
		clk_cnt++;
		if (out_de !== 1'b1) begin
			$display("** Error: out_de = %h, expected 1", out_de);
			raster_errs++;
		end
		if (!arst_n || !scan_en) begin
			if (out_pclk || out_hs || out_vs || sram_we_n !== 1'b1 || sram_oe_n !== 1'b0 ||
					out_data != '0) begin
				$display("** Error: idle pclk=%h hs=%h vs=%h we_n=%h oe_n=%h out_data=%h, exp 0 0 0 1 0 0",
					out_pclk, out_hs, out_vs, sram_we_n, sram_oe_n, out_data);
				reset_errs++;
			end
		end else begin
			if (!sram_we_n) begin
				if (wr_cnt >= n_words) begin
					$display("SRAM write to address %h after the last captured pixel", sram_addr);
					write_errs++;
				end else begin
					row = wr_cnt / `AMIV_CAP_W; // writes arrive in raster order.
					col = wr_cnt % `AMIV_CAP_W;
					exp_w = exp_words[(row % 2) * `AMIV_CAP_W + col]; // stim repeats every two rows.
					if (sram_addr !== sram_addr_t'(row * `AMIV_CAP_W + col)) begin
						$display("** Error: sram_addr = %h, expected %h", sram_addr,
							sram_addr_t'(row * `AMIV_CAP_W + col));
						write_errs++;
					end
					if (sram_wdata !== exp_w) begin
						$display("** Error: sram_wdata = %h, expected %h", sram_wdata, exp_w);
						write_errs++;
					end
					shadow[row * `AMIV_CAP_W + col] = exp_w;
				end
				wr_cnt++;
			end
			if (out_hs && !hs_q) begin
				if (hs_seen && (clk_cnt - hs_rise_at) != 2 * h_total) begin
					$display("** Error: out_hs period = %h clocks, expected %h",
						clk_cnt - hs_rise_at, 2 * h_total);
					raster_errs++;
				end
				if (tracking && pix_pos != `AMIV_OUT_HFP) begin
					$display("hsync rose before output pixel %0d instead of the front porch end", pix_pos);
					raster_errs++;
				end
				hs_rise_at = clk_cnt;
				hs_seen = 1'b1;
				hs_lines++;
			end
			if (!out_hs && hs_q && (clk_cnt - hs_rise_at) != 2 * `AMIV_OUT_HSW) begin
				$display("** Error: out_hs width = %h clocks, expected %h",
					clk_cnt - hs_rise_at, 2 * `AMIV_OUT_HSW);
				raster_errs++;
			end
			if (out_vs && !vs_q) begin
				if (vs_seen && hs_lines != `AMIV_OUT_VTOTAL) begin
					$display("** Error: out_vs period = %h lines, expected %h", hs_lines,
						`AMIV_OUT_VTOTAL);
					raster_errs++;
				end
				if (checking) begin
					done = 1'b1; // one whole frame has been compared.
				end
				checking = !done && (wr_cnt == n_words);
				vs_seen = 1'b1;
				hs_lines = 0;
				tracking = 1'b1;
				line_pos = `AMIV_OUT_VBP; // vsync rises as this line begins.
				pix_pos = 0;
			end
			if (out_pclk && tracking) begin
				if (checking) begin
					if (pix_pos >= `AMIV_OUT_HBLANK && line_pos >= v_first) begin
						row = (line_pos - v_first) / 2; // two output lines per stored line.
						col = (pix_pos - `AMIV_OUT_HBLANK) / 2;
						exp_rgb = expand(shadow[row * `AMIV_CAP_W + col]);
					end else begin
						exp_rgb = '0;
					end
					if (out_data !== exp_rgb) begin
						$display("** Error: out_data = %h, expected %h (pixel %0d, line %0d)",
							out_data, exp_rgb, pix_pos, line_pos);
						pixel_errs++;
					end
					if (pix_pos % 2 == 1 && pix_pos + 1 >= `AMIV_OUT_HBLANK &&
							pix_pos + 1 < h_total && line_pos >= v_first) begin
						row = (line_pos - v_first) / 2; // both lines of a pair read one row.
						col = (pix_pos + 1 - `AMIV_OUT_HBLANK) / 2; // this read feeds the next pair.
						if (sram_addr !== sram_addr_t'(row * `AMIV_CAP_W + col)) begin
							$display("** Error: sram_addr = %h, expected %h (read, line %0d)",
								sram_addr, sram_addr_t'(row * `AMIV_CAP_W + col), line_pos);
							pixel_errs++;
						end
						if (sram_oe_n !== 1'b0) begin
							$display("** Error: sram_oe_n = %h, expected 0 in a read", sram_oe_n);
							pixel_errs++;
						end
					end
				end
				pix_pos++;
				if (pix_pos == h_total) begin
					pix_pos = 0;
					line_pos = (line_pos + 1) % `AMIV_OUT_VTOTAL;
				end
			end
		end
		hs_q = out_hs;
		vs_q = out_vs;
	end
endmodule

`default_nettype wire

// ==== testbench/amiv_stim.hex ====
// columns: 30-bit digitizer pixel {r10, g10, b10}, then the expected RGB565 word.
// sixteen pixels cover two stored lines; even stored rows use the first eight.
01541BEB 021F
03545BCB 0A3E
05549BAB 125D
0754DB8B 1A7C
09551B6B 229B
0B555B4B 2ABA
0D559B2B 32D9
0F55DB0B 3AF8
11561AEB 4317
13565ACB 4B36
15569AAB 5355
1756DA8B 5B74
19571A6B 6393
1B575A4B 6BB2
1D579A2B 73D1
1F57DA0B 7BF0

// ==== testbench/tb_amiv.sv ====
// Testbench of the scan doubler.
// Plays one input frame from the stim file, models the SRAM and lets amiv_checker judge.
`timescale 1ns/1ps
`default_nettype none
`include "amiv_cfg.svh"

module tb_amiv;
	logic        in_hs;
	logic        arst_n;
	logic        scan_en;
	logic        pix_stb;
	logic        line_sync;
	logic        frame_sync;
	logic [29:0] in_data;
	logic [15:0] sram_rdata;
	logic        out_pclk;
	logic        out_hs;
	logic        out_vs;
	logic        out_de;
	logic [23:0] out_data;
	logic        sram_oe_n;
	logic        sram_we_n;
	logic [18:0] sram_addr;
	logic [15:0] sram_wdata;
	logic [31:0] stim_mem [0:4*`AMIV_CAP_W-1]; // pixel and expected word alternate.
	logic [15:0] exp_words [0:2*`AMIV_CAP_W-1];
	logic [15:0] sram_mem [0:1023];
	logic        done;
	int          reset_errs;
	int          write_errs;
	int          raster_errs;
	int          pixel_errs;
	int          wait_cnt;

	always #50 in_hs = ~in_hs;

	assign sram_rdata = sram_mem[sram_addr[9:0]]; // asynchronous read.

	always @(posedge in_hs) begin
		if (!sram_we_n) begin
			sram_mem[sram_addr[9:0]] <= sram_wdata;
		end
	end

	task automatic next_cycle();
		@(posedge in_hs);
		#10;
	endtask

	task automatic play_line(input int line_no);
		int p;
		int idx;
		line_sync = 1'b1;
		next_cycle(); // the line count steps before the first strobe.
		for (p = 0; p < `AMIV_IN_HBLANK + `AMIV_CAP_W + 1; p++) begin
			if (line_no >= `AMIV_IN_VBLANK && line_no < `AMIV_IN_VBLANK + `AMIV_CAP_H &&
					p >= `AMIV_IN_HBLANK && p < `AMIV_IN_HBLANK + `AMIV_CAP_W) begin
				idx = ((line_no - `AMIV_IN_VBLANK) % 2) * `AMIV_CAP_W + (p - `AMIV_IN_HBLANK);
				in_data = stim_mem[2 * idx][29:0];
			end else begin
				in_data = '1; // blanking pixels must never reach the SRAM.
			end
			pix_stb = 1'b1;
			next_cycle();
			pix_stb = 1'b0;
			repeat (3) next_cycle();
		end
		line_sync = 1'b0;
		repeat (2) next_cycle();
	endtask

	amiv_top u_amiv_top (
		.in_hs(in_hs), .arst_n(arst_n), .scan_en(scan_en), .pix_stb(pix_stb),
		.line_sync(line_sync), .frame_sync(frame_sync), .in_data(in_data),
		.sram_rdata(sram_rdata), .out_pclk(out_pclk), .out_hs(out_hs), .out_vs(out_vs),
		.out_de(out_de), .out_data(out_data), .sram_oe_n(sram_oe_n),
		.sram_we_n(sram_we_n), .sram_addr(sram_addr), .sram_wdata(sram_wdata)
	);

	amiv_checker u_checker (
		.in_hs(in_hs), .arst_n(arst_n), .scan_en(scan_en), .exp_words(exp_words),
		.out_pclk(out_pclk), .out_hs(out_hs), .out_vs(out_vs), .out_de(out_de),
		.out_data(out_data), .sram_we_n(sram_we_n), .sram_oe_n(sram_oe_n),
		.sram_addr(sram_addr), .sram_wdata(sram_wdata),
		.done(done), .reset_errs(reset_errs), .write_errs(write_errs),
		.raster_errs(raster_errs), .pixel_errs(pixel_errs)
	);

	initial begin
		in_hs = 1'b0;
		arst_n = 1'b0;
		scan_en = 1'b0;
		pix_stb = 1'b0;
		line_sync = 1'b0;
		frame_sync = 1'b0;
		in_data = '0;
		$readmemh("testbench/amiv_stim.hex", stim_mem);
		for (int i = 0; i < 2 * `AMIV_CAP_W; i++) begin
			exp_words[i] = stim_mem[2 * i + 1][15:0];
		end
		repeat (10) @(posedge in_hs);
		#10;
		arst_n = 1'b1;
		repeat (4) next_cycle(); // outputs stay quiet until scanning starts.
		scan_en = 1'b1;
		frame_sync = 1'b1;
		next_cycle();
		for (int l = 1; l <= `AMIV_IN_VBLANK + `AMIV_CAP_H; l++) begin
			play_line(l);
		end
		wait_cnt = 0;
		while (!done && wait_cnt < 3000) begin
			@(posedge in_hs);
			wait_cnt++;
		end
		if (!done) begin
			$display("checker did not finish a full output frame within 3000 clocks");
		end
		$display("errors: reset %0d, write %0d, raster %0d, pixel %0d",
			reset_errs, write_errs, raster_errs, pixel_errs);
		if (done && (reset_errs + write_errs + raster_errs + pixel_errs) == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end
endmodule

`default_nettype wire
